/* include/fma_settings.svh */
`ifndef FMA_SETTINGS_SVH
`define FMA_SETTINGS_SVH

// binary32 field widths
`define FMA_EXP_BITS 8
`define FMA_MAN_BITS 23

// bias of the stored exponent
`define FMA_EXP_BIAS 127

// aligned product plus addend datapath
// 48 product bits below, 28 bits of room for a larger addend above
`define FMA_SUM_BITS 76

// clock edges from operand sample to result
`define FMA_LATENCY 5

// quiet nan returned for every invalid case
`define FMA_QNAN 32'h7fc0_0000

`endif

/* hdl/fp_format_pkg.sv */
`include "fma_settings.svh"

package fp_format_pkg;

  // one binary32 word split into its fields
  // sign in bit 31, biased exponent next, stored fraction at the bottom
  typedef struct packed {
    logic                     sign;
    logic [`FMA_EXP_BITS-1:0] exp;
    logic [`FMA_MAN_BITS-1:0] frac;
  } fp32_t;

  // operand class after decode
  // exponent all zero -> zero (subnormals included)
  // exponent all ones -> infinity or nan by the fraction
  // anything else -> normal, hidden bit set
  typedef enum logic [1:0] {
    fp_zero,
    fp_normal,
    fp_inf,
    fp_nan
  } fp_class_e;

endpackage

/* hdl/fma_stage_pkg.sv */
`include "fma_settings.svh"

package fma_stage_pkg;

  // signed exponent with room for overflow and underflow
  typedef logic signed [`FMA_EXP_BITS+1:0] sexp_t;

  // what the adder really does after the signs are folded in
  typedef enum logic {
    op_add,
    op_sub
  } eff_op_e;

  // result already known at stage 1, rides along untouched
  typedef struct packed {
    logic                                     is_special;
    logic [`FMA_EXP_BITS+`FMA_MAN_BITS:0]     value;
  } special_s;

  // stage 1 -> stage 2
  // prod_exp is the weight of product bit 46 in the frame
  typedef struct packed {
    logic [`FMA_MAN_BITS:0]   sig_a;
    logic [`FMA_MAN_BITS:0]   sig_b;
    logic [`FMA_MAN_BITS:0]   sig_c;
    logic                     prod_sign;
    logic                     addend_sign;
    sexp_t                    prod_exp;
    logic [`FMA_EXP_BITS-1:0] align_shift;
    // shift direction, left when set
    logic                     addend_larger;
    special_s                 special;
  } s1_s;

  // stage 2 -> stage 3
  // ref_exp is the weight of the frame msb
  typedef struct packed {
    logic [2*`FMA_MAN_BITS+1:0] product;
    logic [`FMA_SUM_BITS-1:0]   addend;
    logic                       sticky;
    eff_op_e                    eff_op;
    sexp_t                      ref_exp;
    logic                       prod_sign;
    special_s                   special;
  } s2_s;

  // stage 3 -> stage 4
  typedef struct packed {
    logic [`FMA_SUM_BITS-1:0] mag;
    logic                     sign;
    sexp_t                    ref_exp;
    logic                     sticky;
    special_s                 special;
  } s3_s;

  // stage 4 -> stage 5
  // sig holds 24 bits then guard, round, sticky
  typedef struct packed {
    logic [`FMA_MAN_BITS+3:0] sig;
    sexp_t                    exp;
    logic                     sign;
    logic                     zero;
    special_s                 special;
  } s4_s;

endpackage

/* hdl/fma_unpack_align.sv */
`include "fma_settings.svh"

module fma_unpack_align (
  input  logic                 clk,
  input  logic                 reset,
  input  fp_format_pkg::fp32_t a,
  input  fp_format_pkg::fp32_t b,
  input  fp_format_pkg::fp32_t c,
  output fma_stage_pkg::s1_s   s1
);
  import fp_format_pkg::*;
  import fma_stage_pkg::*;

  fp_class_e cls_a;
  fp_class_e cls_b;
  fp_class_e cls_c;
  logic      prod_sign;
  logic      prod_inf;
  logic      prod_zero;
  logic      any_nan;
  sexp_t     prod_exp;
  sexp_t     exp_dist;
  sexp_t     shift_full;
  s1_s       s1_next;

  // subnormals fall in with zero
  function automatic fp_class_e classify(input fp32_t x);
    if (x.exp == '0) begin
      return fp_zero;
    end
    if (x.exp == '1) begin
      return (x.frac == '0) ? fp_inf : fp_nan;
    end
    return fp_normal;
  endfunction

  // hidden bit back in front, zero for anything not normal
  function automatic logic [`FMA_MAN_BITS:0] significand(input fp32_t x, input fp_class_e cls);
    return (cls == fp_normal) ? {1'b1, x.frac} : '0;
  endfunction

  always_comb begin
    cls_a = classify(a);
    cls_b = classify(b);
    cls_c = classify(c);
    prod_sign = a.sign ^ b.sign;
    prod_inf  = (cls_a == fp_inf) || (cls_b == fp_inf);
    prod_zero = (cls_a == fp_zero) || (cls_b == fp_zero);
    any_nan   = (cls_a == fp_nan) || (cls_b == fp_nan) || (cls_c == fp_nan);

    // biased product exponent, only meaningful for two normals
    prod_exp = sexp_t'(a.exp) + sexp_t'(b.exp) - sexp_t'(`FMA_EXP_BIAS);
    // positive when c sits above the product
    exp_dist = sexp_t'(c.exp) - prod_exp;

    s1_next             = '0;
    s1_next.sig_a       = significand(a, cls_a);
    s1_next.sig_b       = significand(b, cls_b);
    s1_next.sig_c       = significand(c, cls_c);
    s1_next.prod_sign   = prod_sign;
    s1_next.addend_sign = c.sign;
    s1_next.prod_exp    = prod_exp;
    shift_full          = '0;

    if ((cls_c == fp_normal) && (exp_dist > 0)) begin
      s1_next.addend_larger = 1'b1;
      if (exp_dist > sexp_t'(`FMA_SUM_BITS - 2 * (`FMA_MAN_BITS + 1))) begin
        shift_full = sexp_t'(`FMA_SUM_BITS - 2 * (`FMA_MAN_BITS + 1));
        // far addend, product moved up just under its round bits
        // where it only counts as sticky
        s1_next.prod_exp = sexp_t'(c.exp) - shift_full;
      end else begin
        shift_full = exp_dist;
      end
    end else if (cls_c == fp_normal) begin
      // past the frame width everything lands in sticky anyway
      shift_full = (exp_dist < -sexp_t'(`FMA_SUM_BITS)) ? sexp_t'(`FMA_SUM_BITS) : -exp_dist;
    end
    s1_next.align_shift = shift_full[`FMA_EXP_BITS-1:0];

    // every special result is settled here
    if (any_nan || (prod_inf && prod_zero) ||
        (prod_inf && (cls_c == fp_inf) && (prod_sign != c.sign))) begin
      s1_next.special.is_special = 1'b1;
      s1_next.special.value      = `FMA_QNAN;
    end else if (prod_inf) begin
      s1_next.special.is_special = 1'b1;
      s1_next.special.value = {prod_sign, {`FMA_EXP_BITS{1'b1}}, {`FMA_MAN_BITS{1'b0}}};
    end else if (cls_c == fp_inf) begin
      s1_next.special.is_special = 1'b1;
      s1_next.special.value = {c.sign, {`FMA_EXP_BITS{1'b1}}, {`FMA_MAN_BITS{1'b0}}};
    end else if (prod_zero) begin
      // zero product returns c, two zeros give -0 only if both negative
      s1_next.special.is_special = 1'b1;
      s1_next.special.value = (cls_c == fp_zero) ?
        {prod_sign & c.sign, {(`FMA_EXP_BITS + `FMA_MAN_BITS){1'b0}}} : c;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      s1 <= '0;
    end else begin
      s1 <= s1_next;
    end
  end

endmodule

/* hdl/fma_multiply.sv */
`include "fma_settings.svh"

module fma_multiply (
  input  logic               clk,
  input  logic               reset,
  input  fma_stage_pkg::s1_s s1,
  output fma_stage_pkg::s2_s s2
);
  import fma_stage_pkg::*;

  logic [`FMA_SUM_BITS-1:0]   addend_base;
  logic [2*`FMA_SUM_BITS-1:0] addend_wide;
  s2_s                        s2_next;

  always_comb begin
    // c unit bit lined up with product bit 46
    addend_base = {{(`FMA_SUM_BITS - `FMA_MAN_BITS - 1){1'b0}}, s1.sig_c} << `FMA_MAN_BITS;
    // low half catches whatever a right shift pushes out
    addend_wide = {addend_base, {`FMA_SUM_BITS{1'b0}}} >> s1.align_shift;

    s2_next = '0;
    // full 24x24 significand product
    s2_next.product = s1.sig_a * s1.sig_b;

    if (s1.addend_larger) begin
      // left shift is clamped in stage 1, nothing falls off the top
      s2_next.addend = addend_base << s1.align_shift;
      s2_next.sticky = 1'b0;
    end else begin
      s2_next.addend = addend_wide[2*`FMA_SUM_BITS-1:`FMA_SUM_BITS];
      s2_next.sticky = |addend_wide[`FMA_SUM_BITS-1:0];
    end

    // different signs turn the add into a subtract
    s2_next.eff_op = (s1.prod_sign ^ s1.addend_sign) ? op_sub : op_add;

    // product bit 46 carries prod_exp, frame msb is 29 places up
    // covers the larger operand in both directions
    s2_next.ref_exp =
      sexp_t'(s1.prod_exp + sexp_t'(`FMA_SUM_BITS - 2 * `FMA_MAN_BITS - 1));
    s2_next.prod_sign = s1.prod_sign;
    s2_next.special   = s1.special;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      s2 <= '0;
    end else begin
      s2 <= s2_next;
    end
  end

endmodule

/* hdl/fma_add.sv */
`include "fma_settings.svh"

module fma_add (
  input  logic               clk,
  input  logic               reset,
  input  fma_stage_pkg::s2_s s2,
  output fma_stage_pkg::s3_s s3
);
  import fma_stage_pkg::*;

  logic [`FMA_SUM_BITS-1:0] prod_ext;
  // one extra bit on top holds the borrow
  logic [`FMA_SUM_BITS:0]   raw;
  logic [`FMA_SUM_BITS:0]   raw_neg;
  logic                     negative;
  s3_s                      s3_next;

  always_comb begin
    prod_ext = {{(`FMA_SUM_BITS - 2 * `FMA_MAN_BITS - 2){1'b0}}, s2.product};

    if (s2.eff_op == op_add) begin
      raw = {1'b0, prod_ext} + {1'b0, s2.addend};
    end else begin
      // addend bits lost to sticky make it a little larger
      // so one more is borrowed
      raw = {1'b0, prod_ext} - {1'b0, s2.addend} - {{`FMA_SUM_BITS{1'b0}}, s2.sticky};
    end

    // addend above the product leaves a negative difference
    negative = (s2.eff_op == op_sub) && raw[`FMA_SUM_BITS];
    raw_neg  = -raw;

    s3_next     = '0;
    s3_next.mag = negative ? raw_neg[`FMA_SUM_BITS-1:0] : raw[`FMA_SUM_BITS-1:0];
    // result takes the sign of the larger magnitude
    s3_next.sign = negative ? ~s2.prod_sign : s2.prod_sign;

    // exact cancellation is +0 under nearest even
    if ((s3_next.mag == '0) && !s2.sticky) begin
      s3_next.sign = 1'b0;
    end

    s3_next.ref_exp = s2.ref_exp;
    s3_next.sticky  = s2.sticky;
    s3_next.special = s2.special;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      s3 <= '0;
    end else begin
      s3 <= s3_next;
    end
  end

endmodule

/* hdl/fma_normalize.sv */
`include "fma_settings.svh"

module fma_normalize (
  input  logic               clk,
  input  logic               reset,
  input  fma_stage_pkg::s3_s s3,
  output fma_stage_pkg::s4_s s4
);
  import fma_stage_pkg::*;

  sexp_t                    lead_zeros;
  logic [`FMA_SUM_BITS-1:0] norm;
  logic                     low_sticky;
  s4_s                      s4_next;

  // zeros above the leading one, full width when the sum is zero
  function automatic sexp_t count_zeros(input logic [`FMA_SUM_BITS-1:0] v);
    sexp_t n;
    logic  found;
    n     = '0;
    found = 1'b0;
    for (int i = `FMA_SUM_BITS - 1; i >= 0; i--) begin
      if (!found) begin
        if (v[i]) begin
          found = 1'b1;
        end else begin
          n = n + sexp_t'(1);
        end
      end
    end
    return n;
  endfunction

  always_comb begin
    lead_zeros = count_zeros(s3.mag);
    // leading one moved up to the frame msb
    norm = s3.mag << lead_zeros;

    // everything under the round bit only matters as sticky
    low_sticky = |norm[`FMA_SUM_BITS-`FMA_MAN_BITS-4:0];

    s4_next = '0;
    // 24 kept bits, guard, round, sticky
    s4_next.sig = {norm[`FMA_SUM_BITS-1 -: `FMA_MAN_BITS+1],
                   norm[`FMA_SUM_BITS-`FMA_MAN_BITS-2],
                   norm[`FMA_SUM_BITS-`FMA_MAN_BITS-3],
                   low_sticky | s3.sticky};

    // ref_exp is the weight of the frame msb
    // each zero skipped drops the exponent by one
    s4_next.exp = s3.ref_exp - lead_zeros;

    s4_next.sign    = s3.sign;
    s4_next.zero    = (s3.mag == '0);
    s4_next.special = s3.special;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      s4 <= '0;
    end else begin
      s4 <= s4_next;
    end
  end

endmodule

/* hdl/fma_round_pack.sv */
`include "fma_settings.svh"

module fma_round_pack (
  input  logic                 clk,
  input  logic                 reset,
  input  fma_stage_pkg::s4_s   s4,
  output fp_format_pkg::fp32_t result
);
  import fp_format_pkg::*;
  import fma_stage_pkg::*;

  logic [`FMA_MAN_BITS:0]   sig;
  logic                     guard;
  logic                     round_bit;
  logic                     sticky;
  logic                     round_up;
  logic [`FMA_MAN_BITS+1:0] rounded;
  logic [`FMA_MAN_BITS-1:0] frac;
  sexp_t                    exp_adj;
  fp32_t                    result_next;

  always_comb begin
    {sig, guard, round_bit, sticky} = s4.sig;

    // nearest even, ties go to the even lsb
    round_up = guard & (round_bit | sticky | sig[0]);
    rounded  = {1'b0, sig} + {{(`FMA_MAN_BITS + 1){1'b0}}, round_up};

    // carry out of the significand bumps the exponent
    if (rounded[`FMA_MAN_BITS+1]) begin
      exp_adj = s4.exp + sexp_t'(1);
      frac    = rounded[`FMA_MAN_BITS:1];
    end else begin
      exp_adj = s4.exp;
      frac    = rounded[`FMA_MAN_BITS-1:0];
    end

    if (s4.special.is_special) begin
      result_next = s4.special.value;
    end else if (s4.zero) begin
      result_next = '0;
    end else if (exp_adj > sexp_t'(2 * `FMA_EXP_BIAS)) begin
      // past the largest finite value
      result_next.sign = s4.sign;
      result_next.exp  = '1;
      result_next.frac = '0;
    end else if (exp_adj < sexp_t'(1)) begin
      // below the smallest normal, flushed to signed zero
      result_next.sign = s4.sign;
      result_next.exp  = '0;
      result_next.frac = '0;
    end else begin
      result_next.sign = s4.sign;
      result_next.exp  = exp_adj[`FMA_EXP_BITS-1:0];
      result_next.frac = frac;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      result <= '0;
    end else begin
      result <= result_next;
    end
  end

endmodule

/* hdl/fma_pipelined.sv */
module fma_pipelined (
  input  logic                 clk,
  input  logic                 reset,
  input  fp_format_pkg::fp32_t a,
  input  fp_format_pkg::fp32_t b,
  input  fp_format_pkg::fp32_t c,
  output fp_format_pkg::fp32_t result
);
  import fma_stage_pkg::*;

  // stage records, each one a register in its producer
  s1_s s1;
  s2_s s2;
  s3_s s3;
  s4_s s4;

  // unpack, classify, exponent compare
  fma_unpack_align u_unpack_align (
    .clk   (clk),
    .reset (reset),
    .a     (a),
    .b     (b),
    .c     (c),
    .s1    (s1)
  );

  // 24x24 multiply and addend alignment
  fma_multiply u_multiply (.clk(clk), .reset(reset), .s1(s1), .s2(s2));

  // wide add or subtract
  fma_add u_add (.clk(clk), .reset(reset), .s2(s2), .s3(s3));

  // leading zero count and shift
  fma_normalize u_normalize (.clk(clk), .reset(reset), .s3(s3), .s4(s4));

  // round, range check, pack
  fma_round_pack u_round_pack (.clk(clk), .reset(reset), .s4(s4), .result(result));

endmodule

/* bench/fma_tb.sv */
`include "fma_settings.svh"

module fma_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import fp_format_pkg::*;

  localparam int random_count   = 400;
  localparam int directed_count = 24;
  localparam int clk_period     = 4;

  // one applied triple and the value it has to produce
  // live is clear for idle cycles and the cleared registers
  typedef struct packed {
    logic  live;
    fp32_t a;
    fp32_t b;
    fp32_t c;
    fp32_t expected;
  } entry_t;

  logic   clk;
  logic   reset;
  fp32_t  a;
  fp32_t  b;
  fp32_t  c;
  fp32_t  result;
  entry_t in_flight[$];
  int     seed    = 32'h2503_c520;
  int     errors  = 0;
  int     checks  = 0;
  int     applied = 0;
  int     checked = 0;

  fma_pipelined UUT (.clk(clk), .reset(reset), .a(a), .b(b), .c(c), .result(result));

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // bound from the vector count, with room for reset and drain
  initial begin
    #((random_count + directed_count + 20) * clk_period);
    $display("timeout, results still missing after %0d cycles",
             random_count + directed_count + 20);
    $display("Finished with errors");
    $finish;
  end

  // binary32 to double
  // zero and subnormal read as zero
  function automatic real widen(input fp32_t x);
    logic [10:0] e;
    if (x.exp == '0) begin
      return 0.0;
    end
    e = 11'(int'(x.exp) - `FMA_EXP_BIAS + 1023);
    return $bitstoreal({x.sign, e, x.frac, 29'b0});
  endfunction

  // double to binary32, nearest even
  // overflow to signed infinity, below normal to signed zero
  function automatic fp32_t round_single(input real r);
    logic [63:0] d;
    logic [24:0] kept;
    int          e;
    fp32_t       f;
    d      = $realtobits(r);
    f      = '0;
    f.sign = d[63];
    if (d[62:52] == '0) begin
      return f;
    end
    e    = int'(d[62:52]) - 1023 + `FMA_EXP_BIAS;
    kept = {2'b01, d[51:29]};
    // guard is bit 28, everything under it is sticky
    if (d[28] && ((|d[27:0]) || kept[0])) begin
      kept = kept + 25'd1;
    end
    if (kept[24]) begin
      kept = kept >> 1;
      e    = e + 1;
    end
    if (e > 2 * `FMA_EXP_BIAS) begin
      f.exp = '1;
    end else if (e >= 1) begin
      f.exp  = 8'(e);
      f.frac = kept[22:0];
    end
    return f;
  endfunction

  // exact in double while the operand window stays narrow
  function automatic fp32_t fma_reference(input fp32_t x, input fp32_t y, input fp32_t z);
    return round_single(widen(x) * widen(y) + widen(z));
  endfunction

  // normal operand with exponent in lo .. lo+span-1
  function automatic fp32_t random_normal(input int lo, input int span);
    logic [31:0] r;
    fp32_t       f;
    r      = $random(seed);
    f.sign = r[31];
    f.frac = r[22:0];
    r      = $random(seed);
    f.exp  = 8'(lo + int'(r % 32'(span)));
    return f;
  endfunction

  // operands change on the rising edge, expected value queued alongside
  task automatic drive(input logic live, input fp32_t x, input fp32_t y, input fp32_t z,
                       input fp32_t expected);
    @(posedge clk);
    a <= x;
    b <= y;
    c <= z;
    in_flight.push_back({live, x, y, z, expected});
    if (live) begin
      applied++;
    end
  endtask

  task automatic model_vector(input fp32_t x, input fp32_t y, input fp32_t z);
    drive(1'b1, x, y, z, fma_reference(x, y, z));
  endtask

  task automatic rule_vector(input fp32_t x, input fp32_t y, input fp32_t z, input fp32_t v);
    drive(1'b1, x, y, z, v);
  endtask

  // zeros in give +0 out
  task automatic idle();
    drive(1'b0, '0, '0, '0, '0);
  endtask

  // result is settled at the falling edge
  // front entry lines up once the queue holds more than the latency
  always @(negedge clk) begin : compare
    entry_t e;
    if (in_flight.size() > `FMA_LATENCY) begin
      e = in_flight.pop_front();
      checks++;
      if (e.live) begin
        checked++;
      end
      assert (result === e.expected)
      else begin
        errors++;
        $display("CHECK FAILED at %0t ns: a=%h b=%h c=%h expected %h got %h",
                 $time, e.a, e.b, e.c, e.expected, result);
      end
    end
  end

  initial begin
    fp32_t x;
    fp32_t y;
    fp32_t z;
    reset <= 1'b1;
    a     <= '0;
    b     <= '0;
    c     <= '0;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    // cleared stage registers read as +0
    repeat (`FMA_LATENCY) in_flight.push_back('0);

    // back to back, c from 20 below to 4 above the product
    for (int i = 0; i < random_count; i++) begin
      x = random_normal(120, 15);
      y = random_normal(120, 15);
      z = random_normal(int'(x.exp) + int'(y.exp) - `FMA_EXP_BIAS - 20, 25);
      model_vector(x, y, z);
    end

    // full cancellation, +0
    model_vector(32'h3fc0_0000, 32'h4000_0000, 32'hc040_0000);
    // near cancellation, long normalize shift, tie left even
    model_vector(32'h3f80_0001, 32'h3f80_0001, 32'hbf80_0000);
    model_vector(32'hbf80_0001, 32'h3f80_0001, 32'h3f80_0000);
    // half tie with even lsb stays
    model_vector(32'h3f80_0800, 32'h3f80_0800, 32'h0000_0000);
    // half tie with odd lsb goes up
    model_vector(32'h3f80_0000, 32'h3f80_0001, 32'h3380_0000);
    // all ones rounds up into the next binade
    model_vector(32'h3f80_0000, 32'h3fff_ffff, 32'h3380_0000);

    // nan anywhere
    rule_vector(32'h7f80_0001, 32'h3f80_0000, 32'h3f80_0000, `FMA_QNAN);
    rule_vector(32'h3f80_0000, 32'hffc0_0000, 32'h3f80_0000, `FMA_QNAN);
    rule_vector(32'h3f80_0000, 32'h3f80_0000, 32'h7fa0_0000, `FMA_QNAN);
    // infinity times zero
    rule_vector(32'h7f80_0000, 32'h0000_0000, 32'h3f80_0000, `FMA_QNAN);
    rule_vector(32'h8000_0000, 32'hff80_0000, 32'h3f80_0000, `FMA_QNAN);
    // opposite infinities
    rule_vector(32'h7f80_0000, 32'h3f80_0000, 32'hff80_0000, `FMA_QNAN);
    rule_vector(32'hff80_0000, 32'h3f80_0000, 32'h7f80_0000, `FMA_QNAN);
    // infinite product wins over finite c, sign of the product
    rule_vector(32'hff80_0000, 32'h4000_0000, 32'h40a0_0000, 32'hff80_0000);
    rule_vector(32'h7f80_0000, 32'hc000_0000, 32'h40a0_0000, 32'hff80_0000);
    rule_vector(32'h7f80_0000, 32'h4000_0000, 32'hc0a0_0000, 32'h7f80_0000);
    // zero product returns c unchanged
    rule_vector(32'h0000_0000, 32'h4040_0000, 32'h4049_0fdb, 32'h4049_0fdb);
    rule_vector(32'h8000_0000, 32'h40a0_0000, 32'hbfc0_0000, 32'hbfc0_0000);

    // past the largest finite value
    rule_vector(32'h7f00_0000, 32'h4080_0000, 32'h3f80_0000, 32'h7f80_0000);
    rule_vector(32'hff00_0000, 32'h4080_0000, 32'h3f80_0000, 32'hff80_0000);
    // half the smallest normal flushes to signed zero
    rule_vector(32'h0080_0000, 32'h3f00_0000, 32'h0000_0000, 32'h0000_0000);
    rule_vector(32'h8080_0000, 32'h3f00_0000, 32'h0000_0000, 32'h8000_0000);
    // subnormal a zeroes the product, subnormal c adds nothing
    rule_vector(32'h0000_0001, 32'h4000_0000, 32'h4040_0000, 32'h4040_0000);
    rule_vector(32'h3fc0_0000, 32'h4000_0000, 32'h007f_ffff, 32'h4040_0000);

    // drain until every live triple has come out
    while (checked < applied) begin
      idle();
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* files.f */
+incdir+include
hdl/fp_format_pkg.sv
hdl/fma_stage_pkg.sv
hdl/fma_unpack_align.sv
hdl/fma_multiply.sv
hdl/fma_add.sv
hdl/fma_normalize.sv
hdl/fma_round_pack.sv
hdl/fma_pipelined.sv
bench/fma_tb.sv

/* run_sim.sh */
#!/bin/sh
# build with verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
log=sim.log
verilator --binary --timing --assert --top-module fma_tb -f files.f -o fma_sim \
  > "$log" 2>&1 &&
  ./obj_dir/fma_sim >> "$log" 2>&1 ||
  echo "simulation build or run failed" >> "$log"
grep -q "Finished with no errors" "$log" && echo "PASS, see $log" && exit 0 ||
  { echo "FAIL, see $log"; exit 1; }
